/* lpf_config.svh */
// ---------------------------------------------------------------------------
// Build-time sizes for the MIDI-controlled low-pass filter voice.
// Included by the package and by every module that needs a width or a depth.
// ---------------------------------------------------------------------------
`ifndef LPF_CONFIG_SVH
`define LPF_CONFIG_SVH

// Datapath widths, samples and coefficients are Q2.16
`define LPF_SAMPLE_W    18
`define LPF_ACC_W       48
`define LPF_FRAC_BITS   16

// Biquad taps and input queue size
`define LPF_NUM_COEFS   5
`define LPF_FIFO_DEPTH  4

// MIDI channel of this voice, CC 20..23 map to coefficients 1..4
`define LPF_MIDI_CHANNEL 0
`define LPF_CC_BASE     20

`endif

/* synth_lpf_pkg.sv */
// ---------------------------------------------------------------------------
// Shared types of the filter voice: MIDI messages, coefficient bank,
// MAC request and engine FSM states. Imported by all filter modules.
// ---------------------------------------------------------------------------
`include "lpf_config.svh"

package synth_lpf_pkg;

    // MIDI status nibble
    typedef enum logic [3:0] {
        note_off         = 4'h8,
        note_on          = 4'h9,
        poly_pressure    = 4'ha,
        control_change   = 4'hb,
        program_change   = 4'hc,
        channel_pressure = 4'hd,
        pitch_bend       = 4'he,
        system_msg       = 4'hf
    } midi_cmd_e;

    // One decoded MIDI event, 22 bits
    typedef struct packed {
        midi_cmd_e  cmd;
        logic [3:0] channel;
        logic [6:0] data0;
        logic [6:0] data1;
    } midi_msg_t;

    // Q2.16 sample or coefficient
    typedef logic signed [`LPF_SAMPLE_W-1:0] sample_t;

    // Coefficients c0..c4, c0 in the lowest slot
    typedef sample_t [`LPF_NUM_COEFS-1:0] coef_bank_t;

    // MAC operation, clear loads the product
    typedef enum logic {
        mac_clear = 1'b0,
        mac_acc   = 1'b1
    } mac_op_e;

    // Request from engine to MAC, 38 bits
    typedef struct packed {
        logic    valid;
        mac_op_e op;
        sample_t a;
        sample_t b;
    } mac_req_t;

    // Biquad engine FSM
    typedef enum logic [1:0] {
        st_idle,
        st_taps,
        st_drain,
        st_done
    } lpf_state_e;

endpackage

/* lpf_coef_ctrl.sv */
// ---------------------------------------------------------------------------
// Turns control-change messages on this voice's channel into the five
// biquad coefficients. The bank updates the cycle after the MIDI strobe.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "lpf_config.svh"

module lpf_coef_ctrl (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      midi_rdy,
    input  synth_lpf_pkg::midi_msg_t  midi_msg,
    output synth_lpf_pkg::coef_bank_t coefs
);
    import synth_lpf_pkg::*;

    // Reset bank: 1.0, -1/16, +1/16, -1/16, +1/16
    localparam sample_t COEF_ONE     = 18'h10000;
    localparam sample_t COEF_NEG_16  = 18'h3f000;
    localparam sample_t COEF_POS_16  = 18'h01000;

    logic       cc_hit;
    logic [6:0] cc_offset;
    logic [2:0] cc_idx;
    logic signed [7:0] cc_val;
    sample_t    cc_coef;
    coef_bank_t bank_q;

    // ------------------------------------------------------------------------
    // Event filter
    // ------------------------------------------------------------------------
    // CC on our channel with a mapped controller number only
    assign cc_hit = midi_rdy
                 && (midi_msg.cmd == control_change)
                 && (midi_msg.channel == 4'(`LPF_MIDI_CHANNEL))
                 && (midi_msg.data0 >= 7'(`LPF_CC_BASE))
                 && (midi_msg.data0 <= 7'(`LPF_CC_BASE + 3));

    // CC base selects coefficient 1
    assign cc_offset = midi_msg.data0 - 7'(`LPF_CC_BASE);
    assign cc_idx    = cc_offset[2:0] + 3'd1;

    // Centre the 7-bit value around 64
    assign cc_val = $signed({1'b0, midi_msg.data1}) - 8'sd64;

    // Shift left by 10, sign carried in the top bits
    assign cc_coef = {cc_val, {(`LPF_SAMPLE_W - 8){1'b0}}};

    // ------------------------------------------------------------------------
    // Coefficient bank
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bank_q[0] <= COEF_ONE;
            bank_q[1] <= COEF_NEG_16;
            bank_q[2] <= COEF_POS_16;
            bank_q[3] <= COEF_NEG_16;
            bank_q[4] <= COEF_POS_16;
        end else if (cc_hit) begin
            // Slot 0 is never addressed, idx runs 1..4
            bank_q[cc_idx] <= cc_coef;
        end
    end

    assign coefs = bank_q;

    // Gain term c0 stays at unity for the whole run
    a_c0_fixed: assert property (@(posedge clk) disable iff (reset)
        $stable(bank_q[0]));

endmodule

/* lpf_sample_fifo.sv */
// ---------------------------------------------------------------------------
// Small circular queue for input samples. Writes on the input strobe,
// drops the sample when full and latches a sticky overrun flag.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "lpf_config.svh"

module lpf_sample_fifo (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   sample_in_rdy,
    input  synth_lpf_pkg::sample_t sample_in,
    input  logic                   pop,
    output logic                   not_empty,
    output synth_lpf_pkg::sample_t head_sample,
    output logic                   fifo_overrun
);
    import synth_lpf_pkg::*;

    localparam int DEPTH = `LPF_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    sample_t          mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             push;

    assign full      = (count == CNT_W'(DEPTH));
    assign not_empty = (count != '0);
    // A pop in the same cycle frees the slot even when full
    assign push      = sample_in_rdy && (!full || pop);
    // Head is read straight out of storage
    assign head_sample = mem[rd_ptr];

    // Storage
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= sample_in;
        end
    end

    // ------------------------------------------------------------------------
    // Pointers, count and overrun
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            fifo_overrun <= 1'b0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // Sticky until reset
            if (sample_in_rdy && !push) begin
                fifo_overrun <= 1'b1;
            end
        end
    end

    // Engine only pops what is there
    a_no_pop_empty: assert property (@(posedge clk) disable iff (reset)
        pop |-> not_empty);

endmodule

/* lpf_mac_unit.sv */
// ---------------------------------------------------------------------------
// Two-stage signed multiply-accumulate standing in for a DSP slice.
// Result and overflow flag appear two cycles after the request.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "lpf_config.svh"

module lpf_mac_unit (
    input  logic                          clk,
    input  logic                          reset,
    input  synth_lpf_pkg::mac_req_t       req,
    output logic signed [`LPF_ACC_W-1:0]  result,
    output logic                          ovf
);
    import synth_lpf_pkg::*;

    localparam int ACC_W  = `LPF_ACC_W;
    localparam int PROD_W = 2 * `LPF_SAMPLE_W;
    // Bits at and above 2.0 in the Q.32 product scale
    localparam int RANGE_LSB = 2 * `LPF_FRAC_BITS + 1;

    logic signed [PROD_W-1:0] prod_c;
    logic signed [PROD_W-1:0] s1_prod;
    logic                     s1_prod_ovf;
    logic                     s1_valid;
    mac_op_e                  s1_op;
    logic signed [ACC_W-1:0]  prod_ext;
    logic signed [ACC_W-1:0]  acc_next;
    logic signed [ACC_W-1:0]  acc_q;
    logic [ACC_W-RANGE_LSB-1:0] acc_top;
    logic                     acc_ovf;
    logic                     ovf_q;

    assign prod_c = $signed(req.a) * $signed(req.b);

    // Stage 1 multiplier register
    always_ff @(posedge clk) begin
        s1_prod     <= prod_c;
        // Top two bits differ only when the product reaches +4.0
        s1_prod_ovf <= prod_c[PROD_W-1] ^ prod_c[PROD_W-2];
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s1_op    <= mac_clear;
        end else begin
            s1_valid <= req.valid;
            s1_op    <= req.op;
        end
    end

    // Stage 2 adder input and range check
    always_comb begin
        prod_ext = {{(ACC_W - PROD_W){s1_prod[PROD_W-1]}}, s1_prod};
        acc_next = (s1_op == mac_clear) ? prod_ext : acc_q + prod_ext;
        acc_top  = acc_next[ACC_W-1:RANGE_LSB];
        // Out of +-2.0 unless the upper bits are all equal
        acc_ovf  = !((&acc_top) || !(|acc_top));
    end

    always_ff @(posedge clk) begin
        if (s1_valid) begin
            acc_q <= acc_next;
        end
    end

    // Overflow collects over one clear..acc sequence
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            ovf_q <= 1'b0;
        end else if (s1_valid) begin
            ovf_q <= ((s1_op == mac_acc) && ovf_q) | s1_prod_ovf | acc_ovf;
        end
    end

    assign result = acc_q;
    assign ovf    = ovf_q;

endmodule

/* lpf_biquad_engine.sv */
// ---------------------------------------------------------------------------
// Direct-form-I biquad engine. Pops one sample, runs five taps through the
// shared MAC, saturates the sum and strobes it out eight cycles after pop.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps
`include "lpf_config.svh"

module lpf_biquad_engine (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      not_empty,
    input  synth_lpf_pkg::sample_t    head_sample,
    input  synth_lpf_pkg::coef_bank_t coefs,
    output logic                      pop,
    output logic                      sample_out_rdy,
    output synth_lpf_pkg::sample_t    sample_out,
    output logic                      err_overflow
);
    import synth_lpf_pkg::*;

    localparam int SAMPLE_W = `LPF_SAMPLE_W;
    localparam int ACC_W    = `LPF_ACC_W;
    localparam int FRAC     = `LPF_FRAC_BITS;
    localparam int NUM      = `LPF_NUM_COEFS;
    localparam int TAP_W    = $clog2(NUM);
    // Result bits kept after the Q.32 to Q2.16 shift
    localparam int OUT_MSB  = FRAC + SAMPLE_W - 1;

    localparam sample_t SAT_MAX = {1'b0, {(SAMPLE_W - 1){1'b1}}};
    localparam sample_t SAT_MIN = {1'b1, {(SAMPLE_W - 1){1'b0}}};

    lpf_state_e state_q;
    logic [TAP_W-1:0] tap_q;
    sample_t    x_q;
    coef_bank_t coef_q;
    // Filter history, saturated values
    sample_t    x1_q;
    sample_t    x2_q;
    sample_t    y1_q;
    sample_t    y2_q;

    mac_req_t   mac_req;
    logic signed [ACC_W-1:0] mac_result;
    logic       mac_ovf;
    logic [ACC_W-OUT_MSB-1:0] res_top;
    logic       sat_hit;
    sample_t    y_sat;

    lpf_mac_unit mac_i (
        .clk    (clk       ),
        .reset  (reset     ),
        .req    (mac_req   ),
        .result (mac_result),
        .ovf    (mac_ovf   )
    );

    // Pop and snapshot happen in the same idle cycle
    assign pop = (state_q == st_idle) && not_empty;

    // ------------------------------------------------------------------------
    // Tap sequencing, one MAC request per cycle in st_taps
    // ------------------------------------------------------------------------
    always_comb begin
        mac_req.valid = (state_q == st_taps);
        mac_req.op    = (tap_q == '0) ? mac_clear : mac_acc;
        mac_req.a     = coef_q[tap_q];
        case (tap_q)
            3'd0:    mac_req.b = x_q;
            3'd1:    mac_req.b = x1_q;
            3'd2:    mac_req.b = x2_q;
            3'd3:    mac_req.b = y1_q;
            default: mac_req.b = y2_q;
        endcase
    end

    // Saturate the truncated sum to 18 bits
    always_comb begin
        res_top = mac_result[ACC_W-1:OUT_MSB];
        sat_hit = !((&res_top) || !(|res_top));
        if (!sat_hit) begin
            y_sat = mac_result[OUT_MSB:FRAC];
        end else if (mac_result[ACC_W-1]) begin
            y_sat = SAT_MIN;
        end else begin
            y_sat = SAT_MAX;
        end
    end

    // ------------------------------------------------------------------------
    // FSM, history and output strobe
    // ------------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state_q        <= st_idle;
            tap_q          <= '0;
            x1_q           <= '0;
            x2_q           <= '0;
            y1_q           <= '0;
            y2_q           <= '0;
            sample_out_rdy <= 1'b0;
            err_overflow   <= 1'b0;
        end else begin
            sample_out_rdy <= 1'b0;
            case (state_q)
                st_idle: begin
                    if (not_empty) begin
                        tap_q   <= '0;
                        state_q <= st_taps;
                    end
                end
                st_taps: begin
                    tap_q <= tap_q + 1'b1;
                    if (tap_q == TAP_W'(NUM - 1)) begin
                        state_q <= st_drain;
                    end
                end
                // MAC pipeline still holds the last tap
                st_drain: state_q <= st_done;
                st_done: begin
                    x2_q           <= x1_q;
                    x1_q           <= x_q;
                    y2_q           <= y1_q;
                    y1_q           <= y_sat;
                    err_overflow   <= sat_hit | mac_ovf;
                    sample_out_rdy <= 1'b1;
                    state_q        <= st_idle;
                end
                default: state_q <= st_idle;
            endcase
        end
    end

    // Snapshot at pop, output held until the next result
    always_ff @(posedge clk) begin
        if (pop) begin
            x_q    <= head_sample;
            coef_q <= coefs;
        end
        if (state_q == st_done) begin
            sample_out <= y_sat;
        end
    end

    a_rdy_pulse: assert property (@(posedge clk) disable iff (reset)
        sample_out_rdy |=> !sample_out_rdy);

endmodule

/* synth_lpf_top.sv */
// ---------------------------------------------------------------------------
// Filter voice top level. MIDI CC sets coefficients, samples queue in the
// FIFO and the biquad engine emits one filtered sample per pop.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module synth_lpf_top (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      midi_rdy,
    input  synth_lpf_pkg::midi_msg_t  midi_msg,
    input  logic                      sample_in_rdy,
    input  synth_lpf_pkg::sample_t    sample_in,
    output logic                      sample_out_rdy,
    output synth_lpf_pkg::sample_t    sample_out,
    output logic                      err_overflow,
    output logic                      fifo_overrun
);
    import synth_lpf_pkg::*;

    coef_bank_t coefs;
    logic       pop;
    logic       not_empty;
    sample_t    head_sample;

    // Producer, MIDI to coefficient bank
    lpf_coef_ctrl coef_ctrl_i (
        .clk      (clk     ),
        .reset    (reset   ),
        .midi_rdy (midi_rdy),
        .midi_msg (midi_msg),
        .coefs    (coefs   )
    );

    // Input sample queue
    lpf_sample_fifo sample_fifo_i (
        .clk           (clk          ),
        .reset         (reset        ),
        .sample_in_rdy (sample_in_rdy),
        .sample_in     (sample_in    ),
        .pop           (pop          ),
        .not_empty     (not_empty    ),
        .head_sample   (head_sample  ),
        .fifo_overrun  (fifo_overrun )
    );

    // Consumer, biquad on the MAC
    lpf_biquad_engine biquad_engine_i (
        .clk            (clk           ),
        .reset          (reset         ),
        .not_empty      (not_empty     ),
        .head_sample    (head_sample   ),
        .coefs          (coefs         ),
        .pop            (pop           ),
        .sample_out_rdy (sample_out_rdy),
        .sample_out     (sample_out    ),
        .err_overflow   (err_overflow  )
    );

endmodule

/* tb_synth_lpf.sv */
// ---------------------------------------------------------------------------
// Self-checking testbench for the filter voice. Reads MIDI, sample and
// expected-output records from the data file and checks every output strobe.
// ---------------------------------------------------------------------------
`timescale 1ns/1ps

module tb_synth_lpf;
    import synth_lpf_pkg::*;

    localparam int OUT_TIMEOUT = 200;
    localparam int LATENCY     = 9;
    localparam int MIN_SPACING = 8;

    // Expected sample and overflow flag of one result
    typedef struct packed {
        sample_t sample;
        logic    ovf;
    } expect_t;

    logic      clk;
    logic      reset;
    logic      midi_rdy;
    midi_msg_t midi_msg;
    logic      sample_in_rdy;
    sample_t   sample_in;
    logic      sample_out_rdy;
    sample_t   sample_out;
    logic      err_overflow;
    logic      fifo_overrun;

    expect_t exp_q[$];
    // Negedge counter for latency and pulse spacing
    int      neg_cnt         = 0;
    int      last_in_n       = 0;
    int      last_out_n      = -100;
    logic    latency_pending = 1'b0;
    int      out_count       = 0;

    synth_lpf_top synth_lpf_top_i (
        .clk            (clk           ),
        .reset          (reset         ),
        .midi_rdy       (midi_rdy      ),
        .midi_msg       (midi_msg      ),
        .sample_in_rdy  (sample_in_rdy ),
        .sample_in      (sample_in     ),
        .sample_out_rdy (sample_out_rdy),
        .sample_out     (sample_out    ),
        .err_overflow   (err_overflow  ),
        .fifo_overrun   (fifo_overrun  )
    );

    // 20 ns clock
    initial clk = 1'b0;
    always #10 clk = ~clk;

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            abort_run($sformatf("FAIL at %0t ns: %s = 0x%0h, expected 0x%0h",
                                $time, name, actual, expected));
        end
    endtask

    // Block until every queued result has come out
    task automatic wait_outputs_done();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            if (waited > OUT_TIMEOUT) begin
                abort_run("timeout: no output arrived within 200 cycles");
            end
        end
    endtask

    task automatic idle_gap();
        int unsigned n;
        n = $urandom % 4;
        repeat (n) @(posedge clk);
    endtask

    task automatic send_midi(input logic [3:0] chan, input logic [3:0] cmd,
                             input logic [6:0] d0, input logic [6:0] d1);
        @(posedge clk);
        #2;
        midi_msg.cmd     = midi_cmd_e'(cmd);
        midi_msg.channel = chan;
        midi_msg.data0   = d0;
        midi_msg.data1   = d1;
        midi_rdy         = 1'b1;
        @(posedge clk);
        #2;
        midi_rdy = 1'b0;
    endtask

    // Isolated sample into an idle engine and empty FIFO
    task automatic send_sample(input sample_t value);
        @(posedge clk);
        #2;
        sample_in       = value;
        sample_in_rdy   = 1'b1;
        latency_pending = 1'b1;
        @(posedge clk);
        #2;
        sample_in_rdy = 1'b0;
    endtask

    // ------------------------------------------------------------------------
    // Output monitor sampling registered outputs mid-cycle
    // ------------------------------------------------------------------------
    always @(negedge clk) begin : output_monitor
        expect_t exp_e;
        neg_cnt = neg_cnt + 1;
        if (sample_in_rdy) begin
            last_in_n = neg_cnt;
        end
        if (sample_out_rdy) begin
            if (neg_cnt - last_out_n < MIN_SPACING) begin
                abort_run("two output strobes came less than 8 cycles apart");
            end else if (exp_q.size() == 0) begin
                abort_run("an output strobe arrived with no expected value queued");
            end else begin
                last_out_n = neg_cnt;
                exp_e      = exp_q.pop_front();
                check_value("sample_out", $unsigned(sample_out), $unsigned(exp_e.sample));
                check_value("err_overflow", err_overflow, exp_e.ovf);
                // Strobe to result latency for isolated samples only
                if (latency_pending) begin
                    check_value("latency", neg_cnt - last_in_n, LATENCY);
                    latency_pending = 1'b0;
                end
                out_count++;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Stimulus from the record file
    // ------------------------------------------------------------------------
    initial begin : stimulus
        int          fd;
        string       line;
        logic [7:0]  tag;
        int          nf;
        logic [31:0] fld [7];
        expect_t     exp_e;
        int          i;
        int unsigned seed_out;

        seed_out      = $urandom(32'h30a1);
        reset         = 1'b1;
        midi_rdy      = 1'b0;
        midi_msg      = '{cmd: note_off, channel: 4'h0, data0: 7'h0, data1: 7'h0};
        sample_in_rdy = 1'b0;
        sample_in     = '0;

        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;

        fd = $fopen("lpf_input.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the stimulus file lpf_input.txt");
        end else begin
            while ($fgets(line, fd) != 0) begin
                tag = 8'h20;
                nf  = $sscanf(line, "%c %h %h %h %h %h %h %h", tag,
                              fld[0], fld[1], fld[2], fld[3], fld[4], fld[5], fld[6]);
                case (tag)
                    "M": begin
                        wait_outputs_done();
                        idle_gap();
                        send_midi(fld[0][3:0], fld[1][3:0], fld[2][6:0], fld[3][6:0]);
                    end
                    "S": begin
                        wait_outputs_done();
                        idle_gap();
                        send_sample(fld[0][17:0]);
                    end
                    // Burst on back-to-back cycles
                    "B": begin
                        wait_outputs_done();
                        idle_gap();
                        // Tag and count come before the samples
                        if (nf != int'(fld[0]) + 2) begin
                            abort_run("burst record count does not match its samples");
                        end else begin
                            for (i = 0; i < int'(fld[0]); i++) begin
                                @(posedge clk);
                                #2;
                                sample_in     = fld[i + 1][17:0];
                                sample_in_rdy = 1'b1;
                            end
                            @(posedge clk);
                            #2;
                            sample_in_rdy = 1'b0;
                        end
                    end
                    "E": begin
                        exp_e.sample = fld[0][17:0];
                        exp_e.ovf    = fld[1][0];
                        exp_q.push_back(exp_e);
                    end
                    "O": begin
                        wait_outputs_done();
                        @(posedge clk);
                        #2;
                        check_value("fifo_overrun", fifo_overrun, fld[0][0]);
                    end
                    "#", " ", 8'h0a, 8'h0d: begin
                    end
                    default: begin
                        abort_run($sformatf("unknown record in stimulus file: %s", line));
                    end
                endcase
            end
            $fclose(fd);
            wait_outputs_done();
            $display("checked %0d filter outputs", out_count);
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

/* lpf_input.txt */
# M chan cmd data0 data1 | S sample | B count samples | E sample ovf | O overrun
# All fields hex, samples are 18-bit two's complement Q2.16
# Impulse with reset coefficients 1, -1/16, 1/16, -1/16, 1/16
S 10000
E 10000 0
S 00000
E 3e000 0
S 00000
E 02200 0
S 00000
E 3fbe0 0
S 00000
E 00262 0
S 00000
E 3ff97 0
# Ignored: other channel, note on, CC 24, CC 19
M 1 b 14 7f
M 0 9 14 7f
M 0 b 18 00
M 0 b 13 00
S 08000
E 0802c 0
S 00000
E 3eff6 0
# c1..c4 to zero, flush the history
M 0 b 14 40
M 0 b 15 40
M 0 b 16 40
M 0 b 17 40
S 00000
E 00000 0
S 00000
E 00000 0
# c1 = +0.25, c2 = -0.25
M 0 b 14 50
M 0 b 15 30
S 10000
E 10000 0
S 00000
E 04000 0
S 00000
E 3c000 0
S 00000
E 00000 0
# c1 = 63/64, c2 = 0, saturation both ways
M 0 b 14 7f
M 0 b 15 40
S 1ffff
E 1ffff 0
S 1ffff
E 1ffff 1
S 20000
E 3f7ff 0
S 20000
E 20000 1
S 00000
E 20800 0
# Pass-through, burst of six keeps five
M 0 b 14 40
O 0
B 6 00100 3ff00 12345 2abcd 0f0f0 15555
E 00100 0
E 3ff00 0
E 12345 0
E 2abcd 0
E 0f0f0 0
O 1
S 00042
E 00042 0

/* list.f */
+incdir+.
synth_lpf_pkg.sv
lpf_coef_ctrl.sv
lpf_sample_fifo.sv
lpf_mac_unit.sv
lpf_biquad_engine.sv
synth_lpf_top.sv
tb_synth_lpf.sv
